/* tb/bp_model.svh */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// reference state, moved on once per clock edge
fetch_pkg::pc_t      ref_stack [RAS_DEPTH];
logic [HIST_W-1:0]   ref_hist  [HIST_ENTRIES];
logic [1:0]          ref_ctr   [2**HIST_W];
predict_pkg::track_t ref_dec;
predict_pkg::track_t ref_exe;

task automatic reset_model();
    for (int i = 0; i < RAS_DEPTH; i++) begin
        ref_stack[i] = '0;
    end
    for (int i = 0; i < HIST_ENTRIES; i++) begin
        ref_hist[i] = '0;
    end
    for (int i = 0; i < 2**HIST_W; i++) begin
        ref_ctr[i] = 2'd0;
    end
    ref_dec = '0;
    ref_exe = '0;
endtask

function automatic predict_pkg::pred_t expect_pred(fetch_pkg::fetch_req_t f);
    predict_pkg::pred_t p;
    logic [HIST_W-1:0]  h;
    h = ref_hist[int'(f.pc) % HIST_ENTRIES];
    p.taken = f.jal || f.jalr || ref_ctr[h][1];
    if (f.ret) begin
        p.target = ref_stack[0];
    end else begin
        p.target = f.pc + f.imm;
    end
    return p;
endfunction

function automatic predict_pkg::fix_e expect_fix(predict_pkg::resolve_t r);
    if (!ref_exe.valid)
        return predict_pkg::FIX_NONE;
    if (r.taken && r.target == ref_exe.pred.target)
        return predict_pkg::FIX_NONE;
    if (ref_exe.pred.taken && !r.taken)
        return predict_pkg::FIX_NOT_TAKEN;
    if (!ref_exe.pred.taken && r.taken)
        return predict_pkg::FIX_TAKEN;
    if (ref_exe.pred.taken && r.taken)
        return predict_pkg::FIX_TARGET;
    return predict_pkg::FIX_NONE;   // right to fall through
endfunction

// one clock edge; a stalled edge leaves everything alone
task automatic step_model(fetch_pkg::fetch_req_t f, logic stall, predict_pkg::resolve_t r);
    predict_pkg::pred_t  p;
    predict_pkg::fix_e   fix;
    predict_pkg::track_t entry;
    logic [HIST_W-1:0]   h;
    logic                cond;
    int                  slot;
    fetch_pkg::pc_t      ret_addr;
    if (!stall) begin
        p     = expect_pred(f);
        fix   = expect_fix(r);
        cond  = !(f.jal || f.jalr);
        slot  = int'(f.pc) % HIST_ENTRIES;
        h     = ref_hist[slot];
        // counter training from execute
        if (ref_exe.valid && ref_exe.cond) begin
            if (r.taken && ref_ctr[ref_exe.ctr_idx] != 2'd3) begin
                ref_ctr[ref_exe.ctr_idx] = ref_ctr[ref_exe.ctr_idx] + 2'd1;
            end else if (!r.taken && ref_ctr[ref_exe.ctr_idx] != 2'd0) begin
                ref_ctr[ref_exe.ctr_idx] = ref_ctr[ref_exe.ctr_idx] - 2'd1;
            end
        end
        if (f.predict && cond) begin
            ref_hist[slot] = {h[HIST_W-2:0], p.taken};
        end
        ret_addr = f.compressed ? f.pc + 18'd1 : f.pc + 18'd2;
        if (f.predict && f.call && f.ret) begin
            ref_stack[0] = ret_addr;
        end else if (f.predict && f.call) begin
            for (int i = RAS_DEPTH - 1; i > 0; i--) begin
                ref_stack[i] = ref_stack[i-1];
            end
            ref_stack[0] = ret_addr;
        end else if (f.predict && f.ret) begin
            for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                ref_stack[i] = ref_stack[i+1];
            end
            ref_stack[RAS_DEPTH-1] = '0;
        end
        entry.valid      = f.predict;
        entry.pc         = f.pc;
        entry.compressed = f.compressed;
        entry.cond       = cond;
        entry.pred       = p;
        entry.ctr_idx    = h;
        ref_exe = ref_dec;
        ref_dec = entry;
        if (fix != predict_pkg::FIX_NONE) begin
            ref_dec.valid = 1'b0;   // wrong path
            ref_exe.valid = 1'b0;
        end
    end
endtask

`endif

/* tb/tb_branch_predictor.sv */
module tb_branch_predictor;

    localparam int RAS_DEPTH    = 4;
    localparam int HIST_ENTRIES = 32;
    localparam int HIST_W       = 5;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int START_CYCLES = 4;
    localparam int JUMP_CYCLES  = 400;
    localparam int TRAIN_CYCLES = 1500;
    localparam int RAND_CYCLES  = 2000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + START_CYCLES + JUMP_CYCLES
                                  + 2 * TRAIN_CYCLES + RAND_CYCLES;
    localparam int TIMEOUT      = TOTAL_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD;

    logic                  clk_i;
    logic                  rst_i;
    logic                  stall_i;
    fetch_pkg::fetch_req_t fetch_i;
    predict_pkg::resolve_t resolve_i;
    predict_pkg::pred_t    pred_o;
    predict_pkg::fix_e     fix_o;
    fetch_pkg::pc_t        exec_pc_o;
    logic                  exec_compressed_o;

    string       test_name;
    int unsigned seed;

    `include "bp_model.svh"

    branch_predictor #(
        .RAS_DEPTH    (RAS_DEPTH),
        .HIST_ENTRIES (HIST_ENTRIES),
        .HIST_W       (HIST_W)
    ) i_branch_predictor (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .fetch_i           (fetch_i),
        .stall_i           (stall_i),
        .resolve_i         (resolve_i),
        .pred_o            (pred_o),
        .fix_o             (fix_o),
        .exec_pc_o         (exec_pc_o),
        .exec_compressed_o (exec_compressed_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic fetch_pkg::fetch_req_t random_fetch();
        fetch_pkg::fetch_req_t f;
        int                    kind;
        f            = '0;
        kind         = $urandom % 4;   // two of four are conditional
        f.pc         = fetch_pkg::pc_t'($urandom);
        f.imm        = fetch_pkg::pc_t'($urandom);
        f.compressed = ($urandom % 2) == 0;
        f.jal        = kind == 2;
        f.jalr       = kind == 3;
        f.call       = ($urandom % 4) == 0;
        f.ret        = ($urandom % 4) == 0;
        f.predict    = ($urandom % 4) != 0;
        return f;
    endfunction

    // target often matches so FIX_NONE and FIX_TARGET both show up
    function automatic predict_pkg::resolve_t random_resolve();
        predict_pkg::resolve_t r;
        r.taken = ($urandom % 2) == 0;
        if (ref_exe.valid && ($urandom % 2) == 0) begin
            r.target = ref_exe.pred.target;
        end else begin
            r.target = fetch_pkg::pc_t'($urandom);
        end
        return r;
    endfunction

    // drive, check mid-cycle, then advance the model across the edge
    task automatic run_cycle(input fetch_pkg::fetch_req_t f, input logic stall,
                             input predict_pkg::resolve_t r,
                             output predict_pkg::pred_t seen_pred,
                             output predict_pkg::fix_e seen_fix);
        fetch_i   = f;
        stall_i   = stall;
        resolve_i = r;
        #40;
        seen_pred = pred_o;
        seen_fix  = fix_o;
        check_value("pred_o", expect_pred(f), pred_o);
        check_value("fix_o", expect_fix(r), fix_o);
        if (ref_exe.valid) begin
            check_value("exec_pc_o", ref_exe.pc, exec_pc_o);
            check_value("exec_compressed_o", ref_exe.compressed, exec_compressed_o);
        end
        step_model(f, stall, r);
        @(posedge clk_i);
        #10;
    endtask

    initial begin
        fetch_pkg::fetch_req_t f;
        predict_pkg::resolve_t r;
        predict_pkg::pred_t    seen_pred;
        predict_pkg::fix_e     seen_fix;
        rst_i     = 1'b1;
        stall_i   = 1'b0;
        fetch_i   = '0;
        resolve_i = '0;
        seed      = 32'h540d_80e2;
        void'($urandom(seed));
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk_i);
        #10;
        rst_i = 1'b0;
        reset_model();

        // fresh conditional branch, counters all zero
        f         = '0;
        f.predict = 1'b1;
        f.pc      = fetch_pkg::pc_t'($urandom);
        r.taken   = 1'b1;
        r.target  = fetch_pkg::pc_t'($urandom);
        run_cycle(f, 1'b0, r, seen_pred, seen_fix);
        check_value("taken after reset", 0, seen_pred.taken);
        check_value("fix_o after reset", predict_pkg::FIX_NONE, seen_fix);
        run_cycle('0, 1'b0, r, seen_pred, seen_fix);
        check_value("fix_o in decode", predict_pkg::FIX_NONE, seen_fix);
        run_cycle('0, 1'b0, random_resolve(), seen_pred, seen_fix);
        run_cycle('0, 1'b0, random_resolve(), seen_pred, seen_fix);

        test_name = "jumps_and_returns";
        repeat (JUMP_CYCLES) begin
            run_cycle(random_fetch(), 1'b0, random_resolve(), seen_pred, seen_fix);
        end

        test_name = "train_taken";
        f         = '0;
        f.predict = 1'b1;
        f.pc      = fetch_pkg::pc_t'($urandom);
        f.imm     = fetch_pkg::pc_t'($urandom);
        r.taken   = 1'b1;
        r.target  = f.pc + f.imm;
        repeat (TRAIN_CYCLES) begin
            run_cycle(f, 1'b0, r, seen_pred, seen_fix);
        end
        check_value("taken after training", 1, seen_pred.taken);

        test_name = "train_not_taken";
        r.taken   = 1'b0;
        repeat (TRAIN_CYCLES) begin
            run_cycle(f, 1'b0, r, seen_pred, seen_fix);
        end
        check_value("taken after untraining", 0, seen_pred.taken);

        test_name = "random_with_stalls";
        repeat (RAND_CYCLES) begin
            run_cycle(random_fetch(), ($urandom % 4) == 0, random_resolve(),
                      seen_pred, seen_fix);
        end

        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before all tests finished");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

/* verilog.f */
+incdir+tb
verilog/fetch_pkg.sv
verilog/predict_pkg.sv
verilog/return_stack.sv
verilog/pattern_table.sv
verilog/resolve_tracker.sv
verilog/branch_predictor.sv
tb/tb_branch_predictor.sv

/* verilog/branch_predictor.sv */
module branch_predictor #(
    parameter int RAS_DEPTH    = 4,
    parameter int HIST_ENTRIES = 32,
    parameter int HIST_W       = 5
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  fetch_pkg::fetch_req_t fetch_i,
    input  logic                  stall_i,
    input  predict_pkg::resolve_t resolve_i,
    output predict_pkg::pred_t    pred_o,
    output predict_pkg::fix_e     fix_o,
    output fetch_pkg::pc_t        exec_pc_o,
    output logic                  exec_compressed_o
);

    logic                  accept;
    logic                  lookup_en;
    fetch_pkg::pc_t        ras_top;
    logic                  lookup_taken;
    logic [HIST_W-1:0]     ctr_idx;
    logic                  train_en;
    logic [HIST_W-1:0]     train_idx;
    logic                  train_taken;

    assign accept    = fetch_i.predict & ~stall_i;
    assign lookup_en = accept & ~(fetch_i.jal | fetch_i.jalr);   // conditional only

    return_stack #(
        .RAS_DEPTH    (RAS_DEPTH)
    ) i_return_stack (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .push_i       (accept & fetch_i.call),
        .pop_i        (accept & fetch_i.ret),
        .push_pc_i    (fetch_i.pc),
        .compressed_i (fetch_i.compressed),
        .top_o        (ras_top)
    );

    pattern_table #(
        .HIST_ENTRIES  (HIST_ENTRIES),
        .HIST_W        (HIST_W)
    ) i_pattern_table (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_pc_i   (fetch_i.pc),
        .lookup_en_i   (lookup_en),
        .taken_o       (lookup_taken),
        .ctr_idx_o     (ctr_idx),
        .train_en_i    (train_en),
        .train_idx_i   (train_idx),
        .train_taken_i (train_taken)
    );

    // unconditional jumps are always taken, returns go to the stack top
    always_comb begin
        pred_o.taken  = fetch_i.jal | fetch_i.jalr | lookup_taken;
        pred_o.target = fetch_i.ret ? ras_top : fetch_i.pc + fetch_i.imm;
    end

    resolve_tracker i_resolve_tracker (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .stall_i           (stall_i),
        .fetch_i           (fetch_i),
        .pred_i            (pred_o),
        .ctr_idx_i         (ctr_idx),
        .resolve_i         (resolve_i),
        .fix_o             (fix_o),
        .train_en_o        (train_en),
        .train_idx_o       (train_idx),
        .train_taken_o     (train_taken),
        .exec_pc_o         (exec_pc_o),
        .exec_compressed_o (exec_compressed_o)
    );

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    // half-word PC, bit 0 is never stored
    localparam int PC_W = 18;

    typedef logic [PC_W:1] pc_t;

    // one instruction as fetch and the decoder flags deliver it
    typedef struct packed {
        pc_t  pc;
        pc_t  imm;          // branch offset in half-words
        logic compressed;   // 16-bit encoding
        logic jal;
        logic jalr;
        logic call;         // push return address
        logic ret;          // pop return address
        logic predict;      // control transfer, wants a prediction
    } fetch_req_t;

endpackage

/* verilog/pattern_table.sv */
module pattern_table #(
    parameter int HIST_ENTRIES = 32,
    parameter int HIST_W       = 5
) (
    input  logic              clk_i,
    input  logic              rst_i,
    // fetch side
    input  fetch_pkg::pc_t    lookup_pc_i,
    input  logic              lookup_en_i,
    output logic              taken_o,
    output logic [HIST_W-1:0] ctr_idx_o,
    // execute side
    input  logic              train_en_i,
    input  logic [HIST_W-1:0] train_idx_i,
    input  logic              train_taken_i
);

    localparam int IDX_W       = $clog2(HIST_ENTRIES);
    localparam int CTR_ENTRIES = 2 ** HIST_W;

    logic [HIST_W-1:0] hist_q [HIST_ENTRIES];
    logic [1:0]        ctr_q  [CTR_ENTRIES];

    logic [IDX_W-1:0]  hist_idx;
    logic [HIST_W-1:0] hist_val;
    logic [1:0]        train_ctr;

    // low PC bits pick the local history
    assign hist_idx = lookup_pc_i[IDX_W:1];
    assign hist_val = hist_q[hist_idx];

    // history pattern picks the counter
    assign ctr_idx_o = hist_val;
    assign taken_o   = ctr_q[hist_val][1];

    // speculative history, shifted at fetch with the guess
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < HIST_ENTRIES; i++) begin
                hist_q[i] <= '0;
            end
        end else if (lookup_en_i) begin
            hist_q[hist_idx] <= {hist_val[HIST_W-2:0], taken_o};
        end
    end

    assign train_ctr = ctr_q[train_idx_i];

    // 2-bit saturating counters
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < CTR_ENTRIES; i++) begin
                ctr_q[i] <= 2'b00;
            end
        end else if (train_en_i) begin
            if (train_taken_i) begin
                if (train_ctr != 2'b11) begin
                    ctr_q[train_idx_i] <= train_ctr + 2'b01;
                end
            end else if (train_ctr != 2'b00) begin
                ctr_q[train_idx_i] <= train_ctr - 2'b01;
            end
        end
    end

endmodule

/* verilog/predict_pkg.sv */
package predict_pkg;

    // width of a counter index carried down the pipe
    localparam int CTR_IDX_W = 5;

    typedef logic [CTR_IDX_W-1:0] ctr_idx_t;

    // fetch-time guess
    typedef struct packed {
        logic           taken;
        fetch_pkg::pc_t target;
    } pred_t;

    // what execute actually found
    typedef struct packed {
        logic           taken;
        fetch_pkg::pc_t target;
    } resolve_t;

    // one decode/execute stage entry
    typedef struct packed {
        logic           valid;
        fetch_pkg::pc_t pc;
        logic           compressed;
        logic           cond;       // neither jal nor jalr
        pred_t          pred;
        ctr_idx_t       ctr_idx;    // counter that made the guess
    } track_t;

    typedef enum logic [1:0] {
        FIX_NONE      = 2'd0,
        FIX_NOT_TAKEN = 2'd1,   // should have fallen through
        FIX_TAKEN     = 2'd2,   // should have jumped
        FIX_TARGET    = 2'd3    // jumped, wrong place
    } fix_e;

endpackage

/* verilog/resolve_tracker.sv */
module resolve_tracker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    // fetch stage
    input  fetch_pkg::fetch_req_t fetch_i,
    input  predict_pkg::pred_t    pred_i,
    input  predict_pkg::ctr_idx_t ctr_idx_i,
    // execute stage
    input  predict_pkg::resolve_t resolve_i,
    output predict_pkg::fix_e     fix_o,
    output logic                  train_en_o,
    output predict_pkg::ctr_idx_t train_idx_o,
    output logic                  train_taken_o,
    output fetch_pkg::pc_t        exec_pc_o,
    output logic                  exec_compressed_o
);

    predict_pkg::track_t fetch_entry;
    predict_pkg::track_t dec_q;
    predict_pkg::track_t exe_q;
    logic                target_ok;
    logic                flush;

    always_comb begin
        fetch_entry.valid      = fetch_i.predict;
        fetch_entry.pc         = fetch_i.pc;
        fetch_entry.compressed = fetch_i.compressed;
        fetch_entry.cond       = ~(fetch_i.jal | fetch_i.jalr);
        fetch_entry.pred       = pred_i;
        fetch_entry.ctr_idx    = ctr_idx_i;
    end

    assign target_ok = resolve_i.target == exe_q.pred.target;

    // execute-stage verdict
    always_comb begin
        if (!exe_q.valid) begin
            fix_o = predict_pkg::FIX_NONE;
        end else if (resolve_i.taken && target_ok) begin
            fix_o = predict_pkg::FIX_NONE;
        end else if (exe_q.pred.taken && !resolve_i.taken) begin
            fix_o = predict_pkg::FIX_NOT_TAKEN;
        end else if (!exe_q.pred.taken && resolve_i.taken) begin
            fix_o = predict_pkg::FIX_TAKEN;
        end else if (exe_q.pred.taken && resolve_i.taken) begin
            fix_o = predict_pkg::FIX_TARGET;
        end else begin
            fix_o = predict_pkg::FIX_NONE;  // correctly not taken
        end
    end

    assign flush = fix_o != predict_pkg::FIX_NONE;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_q.valid <= 1'b0;
            exe_q.valid <= 1'b0;
        end else if (!stall_i) begin
            dec_q <= fetch_entry;
            exe_q <= dec_q;
            if (flush) begin
                // younger work came down the wrong path
                dec_q.valid <= 1'b0;
                exe_q.valid <= 1'b0;
            end
        end
    end

    // only conditional branches own a counter
    assign train_en_o    = exe_q.valid & exe_q.cond & ~stall_i;
    assign train_idx_o   = exe_q.ctr_idx;
    assign train_taken_o = resolve_i.taken;

    assign exec_pc_o         = exe_q.pc;
    assign exec_compressed_o = exe_q.compressed;

endmodule

/* verilog/return_stack.sv */
module return_stack #(
    parameter int RAS_DEPTH = 4
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           push_i,
    input  logic           pop_i,
    input  fetch_pkg::pc_t push_pc_i,
    input  logic           compressed_i,
    output fetch_pkg::pc_t top_o
);

    fetch_pkg::pc_t stack_q [RAS_DEPTH];
    fetch_pkg::pc_t step;
    fetch_pkg::pc_t ret_addr;

    // next instruction after the call, in half-words
    assign step     = compressed_i ? fetch_pkg::pc_t'(1) : fetch_pkg::pc_t'(2);
    assign ret_addr = push_pc_i + step;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                stack_q[i] <= '0;
            end
        end else if (push_i && pop_i) begin
            // return then call, depth unchanged
            stack_q[0] <= ret_addr;
        end else if (push_i) begin
            stack_q[0] <= ret_addr;
            for (int i = 1; i < RAS_DEPTH; i++) begin
                stack_q[i] <= stack_q[i-1];     // oldest falls off
            end
        end else if (pop_i) begin
            for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                stack_q[i] <= stack_q[i+1];
            end
            stack_q[RAS_DEPTH-1] <= '0;         // bottom refills empty
        end
    end

    assign top_o = stack_q[0];

endmodule
